//--- Makefile
VERILATOR := verilator
TOP       := spim_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
RUNFLAGS  := +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "FAIL: run ended early"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
hdl/spim_pkg.sv
hdl/spim_clkgen.sv
hdl/spim_tx.sv
hdl/spim_rx.sv
hdl/spim_seq.sv
hdl/spim_top.sv
testbench/spim_properties.sv
testbench/spim_tb.sv

//--- hdl/spim_clkgen.sv
////////////////////////////////////////////////////////////////////////////
// SPI serial clock generator
// Divides clk by 2*(clk_div+1) while enabled and flags the clock cycle
// on which sck is about to rise or fall
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module spim_clkgen
  import spim_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      en,
  input  spim_div_t clk_div,
  output logic      sck,
  output logic      rise,
  output logic      fall
);

  spim_div_t cnt;
  logic      toggle;

  // Compare with >= so a smaller divider written mid-count still wraps
  assign toggle = en && (cnt >= clk_div);

  // Strobes lead the sck edge by one clk, shifters act on the same edge
  assign rise = toggle && !sck;
  assign fall = toggle && sck;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cnt <= '0;
      sck <= 1'b0;
    end
    else if (!en)
    begin
      // Park low so the next phase begins with a full low half period
      cnt <= '0;
      sck <= 1'b0;
    end
    else if (toggle)
    begin
      cnt <= '0;
      sck <= ~sck;
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- hdl/spim_pkg.sv
////////////////////////////////////////////////////////////////////////////
// SPI flash master shared definitions
// Word and length widths, sequencer phases, the host request and the
// outputs that go to the flash
////////////////////////////////////////////////////////////////////////////

package spim_pkg;

  localparam int SPIM_WORD_W  = 32;
  localparam int SPIM_LEN_W   = 6;
  localparam int SPIM_DUMMY_W = 8;
  localparam int SPIM_CS_N    = 4;

  typedef logic [SPIM_WORD_W-1:0] spim_word_t;
  // Bit count of one phase, 0 to 32
  typedef logic [SPIM_LEN_W-1:0]  spim_len_t;
  typedef logic [7:0]             spim_div_t;
  typedef logic [3:0]             spim_lane_t;
  typedef logic [1:0]             spim_cs_t;

  typedef enum logic [2:0] {
    IDLE,
    CMD,
    ADDR,
    DUMMY,
    DATA_TX,
    DATA_RX,
    WAIT_EDGE
  } spim_phase_t;

  // One transaction, held stable by the host until ack
  typedef struct packed {
    logic [7:0]              cmd;
    spim_len_t               cmd_len;
    spim_word_t              addr;
    spim_len_t               addr_len;
    logic [SPIM_DUMMY_W-1:0] dummy_len;   // serial clock cycles
    spim_len_t               data_len;
    logic                    rd;
    logic                    quad;
    spim_word_t              wdata;
    spim_cs_t                cs;
  } spim_req_t;

  typedef struct packed {
    logic                 sck;
    logic [SPIM_CS_N-1:0] csn;
    spim_lane_t           sdo;
    logic                 oe;
  } spim_pad_t;

endpackage

//--- hdl/spim_rx.sv
////////////////////////////////////////////////////////////////////////////
// SPI receive shifter
// Samples MISO, or all four lines in quad mode, on each sck rising edge
// and shifts them in from the LSB end until the bit count is consumed
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module spim_rx
  import spim_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  logic       start,
  input  spim_len_t  bits,
  input  logic       quad,
  input  logic       rise,
  input  spim_lane_t sdi,
  output spim_word_t data,
  output logic       done
);

  spim_len_t remain;
  spim_len_t step;
  logic      quad_q;
  logic      sample;

  assign step   = quad_q ? spim_len_t'(4) : spim_len_t'(1);
  assign sample = rise && (remain != '0);

  // Single line reads come in on DQ1, sdi[3] is the nibble MSB in quad
  always_ff @(posedge clk)
  begin
    if (start)
      data <= '0;
    else if (sample)
      data <= quad_q ? {data[SPIM_WORD_W-5:0], sdi} : {data[SPIM_WORD_W-2:0], sdi[1]};
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      remain <= '0;
      quad_q <= 1'b0;
      done   <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (start)
      begin
        remain <= bits;
        quad_q <= quad;
      end
      else if (sample)
      begin
        if (remain <= step)
        begin
          remain <= '0;
          done   <= 1'b1;
        end
        else
          remain <= remain - step;
      end
    end
  end

endmodule

//--- hdl/spim_seq.sv
////////////////////////////////////////////////////////////////////////////
// SPI flash phase sequencer
// Walks a request through command, address, dummy and data phases,
// skipping empty ones, loads the shifters, drives chip select, output
// enable and the serial clock enable, and acknowledges the host
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module spim_seq
  import spim_pkg::*;
(
  input  logic                 clk,
  input  logic                 rstn,
  input  spim_req_t            req,
  input  logic                 req_valid,
  input  logic                 tx_done,
  input  logic                 rx_done,
  output logic                 tx_start,
  output spim_word_t           tx_word,
  output spim_len_t            tx_bits,
  output logic                 tx_quad,
  output logic                 rx_start,
  output spim_len_t            rx_bits,
  output logic                 rx_quad,
  output logic                 clk_en,
  output logic [SPIM_CS_N-1:0] csn,
  output logic                 oe,
  output logic                 ack
);

  spim_phase_t state;
  spim_phase_t state_next;
  spim_phase_t nxt_phase;
  spim_len_t   dummy_bits;
  logic        shifting;
  logic        phase_done;
  logic        launch;

  // First non-empty phase after cur, WAIT_EDGE when nothing is left
  function automatic spim_phase_t pick_next(spim_phase_t cur, spim_req_t r);
    spim_phase_t nxt;
    nxt = WAIT_EDGE;
    if (r.data_len != '0 && cur inside {IDLE, CMD, ADDR, DUMMY})
      nxt = r.rd ? DATA_RX : DATA_TX;
    if (r.dummy_len != '0 && cur inside {IDLE, CMD, ADDR})
      nxt = DUMMY;
    if (r.addr_len != '0 && cur inside {IDLE, CMD})
      nxt = ADDR;
    if (r.cmd_len != '0 && cur == IDLE)
      nxt = CMD;
    return nxt;
  endfunction

  assign nxt_phase  = pick_next(state, req);
  assign shifting   = state inside {CMD, ADDR, DUMMY, DATA_TX, DATA_RX};
  assign phase_done = (state inside {CMD, ADDR, DUMMY, DATA_TX} && tx_done) ||
                      (state == DATA_RX && rx_done);
  assign launch     = (state == IDLE && req_valid) || phase_done;

  // Dummy cycles to bits, four per serial cycle in quad
  assign dummy_bits = req.quad ? {req.dummy_len[SPIM_LEN_W-3:0], 2'b00}
                               : req.dummy_len[SPIM_LEN_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Shifter loads
  ////////////////////////////////////////////////////////////////////////////

  assign tx_start = launch && (nxt_phase inside {CMD, ADDR, DUMMY, DATA_TX});
  assign tx_quad  = (nxt_phase == CMD) ? 1'b0 : req.quad;
  assign rx_start = launch && (nxt_phase == DATA_RX);
  assign rx_bits  = req.data_len;
  assign rx_quad  = req.quad;

  always_comb
  begin
    tx_word = '0;
    tx_bits = dummy_bits;
    case (nxt_phase)
      CMD:
      begin
        tx_word = {req.cmd, {(SPIM_WORD_W - $bits(req.cmd)){1'b0}}};
        tx_bits = req.cmd_len;
      end
      ADDR:
      begin
        tx_word = req.addr;
        tx_bits = req.addr_len;
      end
      DATA_TX:
      begin
        tx_word = req.wdata;
        tx_bits = req.data_len;
      end
      default:
      begin
        tx_word = '0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Phase machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:      if (req_valid) state_next = nxt_phase;
      WAIT_EDGE: state_next = IDLE;
      default:   if (phase_done) state_next = nxt_phase;
    endcase
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      state <= IDLE;
    else
      state <= state_next;
  end

  // Clock pauses for the hand-over cycle so each phase starts from sck low
  assign clk_en = shifting && !phase_done;
  assign oe     = state inside {CMD, ADDR, DUMMY, DATA_TX};
  assign ack    = (state == WAIT_EDGE);

  always_comb
  begin
    csn = '1;
    if (state != IDLE)
      csn[req.cs] = 1'b0;
  end

endmodule

//--- hdl/spim_top.sv
////////////////////////////////////////////////////////////////////////////
// SPI / quad SPI flash master
// Sequencer, serial clock generator and the two shifters, with the
// flash-side outputs gathered into one pad struct
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module spim_top
  import spim_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  spim_div_t  clk_div,
  input  spim_req_t  req,
  input  logic       req_valid,
  output logic       ack,
  output spim_word_t rdata,
  output spim_pad_t  pad,
  input  spim_lane_t sdi
);

  logic                 tx_start;
  spim_word_t           tx_word;
  spim_len_t            tx_bits;
  logic                 tx_quad;
  logic                 tx_done;
  logic                 rx_start;
  spim_len_t            rx_bits;
  logic                 rx_quad;
  logic                 rx_done;
  logic                 clk_en;
  logic                 sck;
  logic                 rise;
  logic                 fall;
  logic [SPIM_CS_N-1:0] csn;
  logic                 oe;
  spim_lane_t           sdo;

  spim_seq u_seq (
    .clk       (clk),
    .rstn      (rstn),
    .req       (req),
    .req_valid (req_valid),
    .tx_done   (tx_done),
    .rx_done   (rx_done),
    .tx_start  (tx_start),
    .tx_word   (tx_word),
    .tx_bits   (tx_bits),
    .tx_quad   (tx_quad),
    .rx_start  (rx_start),
    .rx_bits   (rx_bits),
    .rx_quad   (rx_quad),
    .clk_en    (clk_en),
    .csn       (csn),
    .oe        (oe),
    .ack       (ack)
  );

  spim_clkgen u_clkgen (
    .clk     (clk),
    .rstn    (rstn),
    .en      (clk_en),
    .clk_div (clk_div),
    .sck     (sck),
    .rise    (rise),
    .fall    (fall)
  );

  spim_tx u_tx (
    .clk   (clk),
    .rstn  (rstn),
    .start (tx_start),
    .word  (tx_word),
    .bits  (tx_bits),
    .quad  (tx_quad),
    .fall  (fall),
    .sdo   (sdo),
    .done  (tx_done)
  );

  spim_rx u_rx (
    .clk   (clk),
    .rstn  (rstn),
    .start (rx_start),
    .bits  (rx_bits),
    .quad  (rx_quad),
    .rise  (rise),
    .sdi   (sdi),
    .data  (rdata),
    .done  (rx_done)
  );

  assign pad = '{sck: sck, csn: csn, sdo: sdo, oe: oe};

endmodule

//--- hdl/spim_tx.sv
////////////////////////////////////////////////////////////////////////////
// SPI transmit shifter
// Sends a left-aligned word MSB first on one line or as nibbles on four
// lines, advancing on each sck falling edge, and pulses done when the
// programmed number of bits has gone out
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module spim_tx
  import spim_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  logic       start,
  input  spim_word_t word,
  input  spim_len_t  bits,
  input  logic       quad,
  input  logic       fall,
  output spim_lane_t sdo,
  output logic       done
);

  spim_word_t shreg;
  spim_len_t  remain;
  spim_len_t  step;
  logic       quad_q;
  logic       shift;

  assign step  = quad_q ? spim_len_t'(4) : spim_len_t'(1);
  assign shift = fall && (remain != '0);

  // First bit is on the lines as soon as the word is loaded
  assign sdo = quad_q ? shreg[SPIM_WORD_W-1 -: 4] : {3'b000, shreg[SPIM_WORD_W-1]};

  ////////////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (start)
      shreg <= word;
    else if (shift)
      shreg <= quad_q ? (shreg << 4) : (shreg << 1);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bit counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      remain <= '0;
      quad_q <= 1'b0;
      done   <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (start)
      begin
        remain <= bits;
        quad_q <= quad;
      end
      else if (shift)
      begin
        // Last fall, the final bit has been sampled by the flash
        if (remain <= step)
        begin
          remain <= '0;
          done   <= 1'b1;
        end
        else
          remain <= remain - step;
      end
    end
  end

endmodule

//--- testbench/spim_properties.sv
////////////////////////////////////////////////////////////////////////////
// SPI flash master pad and handshake properties
// Bound into the master top level, checks chip select, serial clock
// idle level and the shape of the acknowledge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module spim_properties
  import spim_pkg::*;
(
  input logic      clk,
  input logic      rstn,
  input logic      req_valid,
  input logic      ack,
  input spim_pad_t pad
);

  int fail_cnt = 0;

  one_select_a: assert property (@(posedge clk) disable iff (!rstn) $onehot0(~pad.csn))
    else begin fail_cnt++; $error("more than one chip select low"); end

  // Serial clock parks low between transactions
  sck_idle_a: assert property (@(posedge clk) disable iff (!rstn) (&pad.csn) |-> !pad.sck)
    else begin fail_cnt++; $error("sck high with no chip select low"); end

  ack_valid_a: assert property (@(posedge clk) disable iff (!rstn) ack |-> req_valid)
    else begin fail_cnt++; $error("ack without a valid request"); end

  ack_pulse_a: assert property (@(posedge clk) disable iff (!rstn) ack |=> !ack)
    else begin fail_cnt++; $error("ack longer than one cycle"); end

endmodule

bind spim_top spim_properties props_i (
  .clk       (clk),
  .rstn      (rstn),
  .req_valid (req_valid),
  .ack       (ack),
  .pad       (pad)
);

//--- testbench/spim_tb.sv
////////////////////////////////////////////////////////////////////////////
// SPI flash master testbench
// Flash slave model on the pad outputs, directed write, read, command-only
// and divider tests, with a closing error summary
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module spim_tb
  import spim_pkg::*;
();

  localparam int CLK_PERIOD  = 8;
  localparam int ACK_TIMEOUT = 20000;

  logic       clk = 1'b0;
  logic       rstn;
  spim_div_t  clk_div;
  spim_req_t  req;
  logic       req_valid;
  logic       ack;
  spim_word_t rdata;
  spim_pad_t  pad;
  spim_lane_t sdi;

  // Flash model state
  logic                 sck;
  logic                 sel_idle;
  logic                 sel_q = 1'b1;
  logic                 model_quad;
  spim_word_t           rd_word = '0;
  logic [31:0]          seed = 32'h47ba;
  spim_word_t           sent_q[$];
  spim_lane_t           cap_sdo[$];
  logic [SPIM_CS_N-1:0] cap_csn[$];
  time                  cap_t[$];
  int                   sck_rises = 0;
  int                   rd_rises = 0;
  int                   mismatches = 0;
  int                   failures = 0;
  spim_word_t           ack_rdata;

  always #(CLK_PERIOD / 2) clk = ~clk;

  spim_top dut_i (
    .clk       (clk),
    .rstn      (rstn),
    .clk_div   (clk_div),
    .req       (req),
    .req_valid (req_valid),
    .ack       (ack),
    .rdata     (rdata),
    .pad       (pad),
    .sdi       (sdi)
  );

  assign sck      = pad.sck;
  assign sel_idle = &pad.csn;
  // Single line reads return on DQ1
  assign sdi = model_quad ? rd_word[31:28] : {2'b00, rd_word[31], 1'b0};

  function automatic spim_word_t lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Flash slave model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge sck)
  begin
    sck_rises <= sck_rises + 1;
    if (!sel_idle && pad.oe)
    begin
      cap_sdo.push_back(pad.sdo);
      cap_csn.push_back(pad.csn);
      cap_t.push_back($time);
    end
    else if (!sel_idle)
      rd_rises <= rd_rises + 1;
  end

  // New read word when a select drops, next bit or nibble on each fall
  always @(negedge sck or posedge sel_idle or negedge sel_idle)
  begin : read_drive
    spim_word_t w;
    if (sel_q && !sel_idle)
    begin
      w = lcg_next();
      rd_word <= w;
      sent_q.push_back(w);
    end
    else if (!sel_idle && !pad.oe)
      rd_word <= model_quad ? (rd_word << 4) : (rd_word << 1);
    sel_q <= sel_idle;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks and helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input spim_word_t got, input spim_word_t exp, input string what);
    if (got !== exp)
    begin
      mismatches++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cs(input spim_cs_t got, input spim_cs_t exp, input string what);
    if (got !== exp)
    begin
      mismatches++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp)
    begin
      mismatches++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  function automatic spim_word_t top_mask(int n);
    spim_word_t ones;
    ones = '1;
    return (n == 0) ? '0 : (ones << (SPIM_WORD_W - n));
  endfunction

  // Rebuilds a left-aligned word from captured cycles
  function automatic spim_word_t gather(int first, int count, logic quad);
    spim_word_t w;
    w = '0;
    for (int i = first; i < first + count; i++)
      w = quad ? {w[SPIM_WORD_W-5:0], cap_sdo[i]} : {w[SPIM_WORD_W-2:0], cap_sdo[i][0]};
    return w << (SPIM_WORD_W - (quad ? 4 * count : count));
  endfunction

  function automatic spim_cs_t select_of(logic [SPIM_CS_N-1:0] csn);
    spim_cs_t idx;
    idx = '0;
    for (int j = 0; j < SPIM_CS_N; j++)
      if (!csn[j])
        idx = spim_cs_t'(j);
    return idx;
  endfunction

  function automatic spim_req_t make_req(logic [7:0] cmd, spim_word_t addr, spim_len_t addr_len,
                                         logic [7:0] dummy, spim_len_t data_len, logic rd,
                                         logic quad, spim_word_t wdata, spim_cs_t cs);
    spim_req_t r;
    r = '{cmd: cmd, cmd_len: 6'd8, addr: addr, addr_len: addr_len, dummy_len: dummy,
          data_len: data_len, rd: rd, quad: quad, wdata: wdata, cs: cs};
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Transfer driver and checker
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_xfer(input spim_req_t r);
    int   cycles;
    logic got;
    cycles = 0;
    got    = 1'b0;
    model_quad <= r.quad;
    req        <= r;
    req_valid  <= 1'b1;
    while (!got && cycles < ACK_TIMEOUT)
    begin
      @(posedge clk);
      cycles++;
      if (ack)
      begin
        got       = 1'b1;
        ack_rdata = rdata;
        req_valid <= 1'b0;
      end
    end
    if (!got)
    begin
      $display("timeout: no ack within %0d cycles", ACK_TIMEOUT);
      $display("Simulation failed");
      $finish;
    end
    else
      @(posedge clk);
  endtask

  task automatic do_xfer(input spim_req_t r, input string name, output int base);
    int q;
    int n_addr;
    int n_dummy;
    int n_data;
    int at;
    int rd_base;
    base    = cap_sdo.size();
    rd_base = rd_rises;
    run_xfer(r);
    q       = r.quad ? 4 : 1;
    n_addr  = int'(r.addr_len) / q;
    n_dummy = int'(r.dummy_len);
    n_data  = r.rd ? 0 : int'(r.data_len) / q;
    check_count(cap_sdo.size() - base, int'(r.cmd_len) + n_addr + n_dummy + n_data,
                {name, " captured cycles"});
    at = base;
    check_word(gather(at, int'(r.cmd_len), 1'b0), {r.cmd, 24'h0} & top_mask(int'(r.cmd_len)),
               {name, " command"});
    at += int'(r.cmd_len);
    check_word(gather(at, n_addr, r.quad), r.addr & top_mask(int'(r.addr_len)),
               {name, " address"});
    at += n_addr;
    check_word(gather(at, n_dummy, r.quad), '0, {name, " dummy"});
    at += n_dummy;
    if (!r.rd)
      check_word(gather(at, n_data, r.quad), r.wdata & top_mask(int'(r.data_len)),
                 {name, " write data"});
    else
    begin
      check_count(rd_rises - rd_base, int'(r.data_len) / q, {name, " read cycles"});
      check_word(ack_rdata, sent_q[$] >> (SPIM_WORD_W - int'(r.data_len)), {name, " rdata"});
    end
    for (int i = base; i < cap_sdo.size(); i++)
    begin
      if ($countones(~cap_csn[i]) != 1)
      begin
        failures++;
        $display("%0t: %s: selects %b do not show exactly one low", $time, name, cap_csn[i]);
      end
      else
        check_cs(select_of(cap_csn[i]), r.cs, {name, " chip select"});
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_std_write();
    int base;
    do_xfer(make_req(8'h02, 32'h1234_5600, 6'd24, 8'd0, 6'd32, 1'b0, 1'b0, 32'hcafe_f00d,
                     2'd0), "standard write", base);
  endtask

  task automatic test_quad_write();
    int base;
    do_xfer(make_req(8'h32, 32'h00ab_cd00, 6'd24, 8'd0, 6'd16, 1'b0, 1'b1, 32'h5a3c_0000,
                     2'd2), "quad write", base);
  endtask

  task automatic test_std_read();
    int base;
    do_xfer(make_req(8'h0b, 32'h0010_2000, 6'd24, 8'd8, 6'd32, 1'b1, 1'b0, 32'h0,
                     2'd1), "standard read", base);
  endtask

  task automatic test_quad_read();
    int base;
    do_xfer(make_req(8'heb, 32'h7f00_1000, 6'd24, 8'd4, 6'd12, 1'b1, 1'b1, 32'h0,
                     2'd3), "quad read", base);
  endtask

  task automatic test_cmd_only();
    int base;
    int rises;
    do_xfer(make_req(8'h06, 32'h0, 6'd0, 8'd0, 6'd0, 1'b0, 1'b0, 32'h0, 2'd1),
            "command only", base);
    rises = sck_rises;
    // Bus must stay quiet once the host has its ack
    repeat (16) @(posedge clk);
    check_count(sck_rises - rises, 0, "sck edges after ack");
    check_count($countones(~pad.csn), 0, "selects low after ack");
  endtask

  task automatic test_divider(input spim_div_t div);
    int base;
    int first;
    clk_div <= div;
    @(posedge clk);
    do_xfer(make_req(8'h02, 32'h0456_7800, 6'd24, 8'd0, 6'd32, 1'b0, 1'b0, 32'h1357_9bdf,
                     2'd0), "divider write", base);
    first = base + 8 + 24;
    for (int i = first + 1; i < base + 64; i++)
      check_count(int'((cap_t[i] - cap_t[i-1]) / CLK_PERIOD), 2 * (int'(div) + 1),
                  "sck period in clocks");
  endtask

  initial
  begin
    rstn       = 1'b0;
    req        = '0;
    req_valid  = 1'b0;
    clk_div    = 8'd1;
    model_quad = 1'b0;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    check_count(int'(pad.sck) + int'(pad.oe) + int'(ack), 0, "active outputs after reset");
    check_count($countones(~pad.csn), 0, "selects low after reset");
    test_std_write();
    test_quad_write();
    test_std_read();
    test_quad_read();
    test_cmd_only();
    test_divider(8'd0);
    test_divider(8'd2);
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, failures, dut_i.props_i.fail_cnt);
    if (mismatches == 0 && failures == 0 && dut_i.props_i.fail_cnt == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
